// File: hdl/core_pkg.sv
// shared widths, operation codes and payload structs for the core
// also the reorder-buffer entry state enum

package core_pkg;

  ////////////////////
  // sizes
  ////////////////////

  localparam int NUM_REGS  = 8;
  localparam int ROB_DEPTH = 16;
  localparam int ROB_TAG_W = $clog2(ROB_DEPTH);

  // operand / result word
  typedef logic [15:0] data_t;
  // architectural register index
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
  // reorder-buffer entry index
  typedef logic [ROB_TAG_W-1:0] rob_tag_t;
  // occupancy, 0 up to ROB_DEPTH inclusive
  typedef logic [ROB_TAG_W:0] rob_count_t;

  ////////////////////
  // operation codes
  ////////////////////

  typedef logic [1:0] op_t;
  localparam op_t OP_ADD = 2'd0;
  localparam op_t OP_SUB = 2'd1;
  localparam op_t OP_XOR = 2'd2;
  // low 16 bits of the product
  localparam op_t OP_MUL = 2'd3;

  ////////////////////
  // payloads
  ////////////////////

  // dispatch port
  typedef struct packed {
    op_t      op;
    reg_idx_t dest;
    reg_idx_t src1;
    reg_idx_t src2;
  } instr_t;

  // decode to execute
  typedef struct packed {
    op_t      op;
    rob_tag_t tag;
    data_t    a;
    data_t    b;
  } issue_t;

  // result bus from one execute path
  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    data_t    value;
  } complete_t;

  // one retire slot
  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    reg_idx_t dest;
    data_t    value;
  } retire_t;

  // per-entry state
  typedef enum logic [1:0] {
    ROBE_EMPTY = 2'd0,
    ROBE_BUSY  = 2'd1,
    ROBE_DONE  = 2'd2
  } rob_state_t;

endpackage

// File: hdl/decode_stage.sv
// decode stage: rename table, operand select, dispatch handshake
// and the registered issue payload toward execute
`timescale 1ns/100ps

module decode_stage (
  input  logic               clock,
  input  logic               reset,
  // dispatch port
  input  logic               dispatch_valid,
  input  core_pkg::instr_t   dispatch_instr,
  output logic               dispatch_ready,
  // reorder buffer allocation
  input  logic               rob_full,
  output logic               alloc,
  input  core_pkg::rob_tag_t alloc_tag,
  // reorder buffer operand lookups
  output core_pkg::rob_tag_t lookup_tag_a,
  output core_pkg::rob_tag_t lookup_tag_b,
  input  logic               lookup_done_a,
  input  logic               lookup_done_b,
  input  core_pkg::data_t    lookup_value_a,
  input  core_pkg::data_t    lookup_value_b,
  // register file reads, indexed by src1/src2 at the top
  input  core_pkg::data_t    rf_value_a,
  input  core_pkg::data_t    rf_value_b,
  // retiring entries
  input  core_pkg::retire_t  retire0,
  input  core_pkg::retire_t  retire1,
  // to execute
  output logic               issue_valid,
  output core_pkg::issue_t   issue
);

  import core_pkg::*;

  // rename table, one busy bit and producer tag per register
  logic [NUM_REGS-1:0] rename_busy;
  rob_tag_t            rename_tag [NUM_REGS];

  logic  src_ready_a;
  logic  src_ready_b;
  logic  transfer;
  data_t operand_a;
  data_t operand_b;

  ////////////////////
  // source readiness
  ////////////////////

  // producer tags for the two sources
  assign lookup_tag_a = rename_tag[dispatch_instr.src1];
  assign lookup_tag_b = rename_tag[dispatch_instr.src2];

  // usable if committed, or producer already done in the rob
  // no bypass from a completion in this same cycle
  assign src_ready_a = !rename_busy[dispatch_instr.src1] || lookup_done_a;
  assign src_ready_b = !rename_busy[dispatch_instr.src2] || lookup_done_b;

  assign dispatch_ready = !rob_full && src_ready_a && src_ready_b;
  assign transfer       = dispatch_valid && dispatch_ready;
  assign alloc          = transfer;

  // operand pick: rob value while renamed, else register file
  assign operand_a = rename_busy[dispatch_instr.src1] ? lookup_value_a : rf_value_a;
  assign operand_b = rename_busy[dispatch_instr.src2] ? lookup_value_b : rf_value_b;

  ////////////////////
  // rename update
  ////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      rename_busy <= '0;
      for (int r = 0; r < NUM_REGS; r++)
      begin
        rename_tag[r] <= '0;
      end
    end
    else
    begin
      // drop mappings whose producer leaves the rob
      for (int r = 0; r < NUM_REGS; r++)
      begin
        if (retire0.valid && rename_busy[r] && retire0.tag == rename_tag[r])
        begin
          rename_busy[r] <= 1'b0;
        end
        if (retire1.valid && rename_busy[r] && retire1.tag == rename_tag[r])
        begin
          rename_busy[r] <= 1'b0;
        end
      end
      // new mapping last, overrides a clear at this edge
      if (transfer)
      begin
        rename_busy[dispatch_instr.dest] <= 1'b1;
        rename_tag[dispatch_instr.dest]  <= alloc_tag;
      end
    end
  end

  ////////////////////
  // issue register
  ////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      issue_valid <= 1'b0;
    end
    else
    begin
      issue_valid <= transfer;
    end
  end

  // payload only, valid qualifies it
  always_ff @(posedge clock)
  begin
    if (transfer)
    begin
      issue.op  <= dispatch_instr.op;
      issue.tag <= alloc_tag;
      issue.a   <= operand_a;
      issue.b   <= operand_b;
    end
  end

endmodule

// File: hdl/execute_unit.sv
// execute unit: single-cycle alu path and pipelined multiplier path
// each path drives its own completion bus
`timescale 1ns/100ps

module execute_unit #(
  parameter int MUL_LATENCY = 3
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                issue_valid,
  input  core_pkg::issue_t    issue,
  output core_pkg::complete_t alu_complete,
  output core_pkg::complete_t mul_complete
);

  import core_pkg::*;

  data_t    alu_result;
  data_t    mul_product;
  logic     alu_valid_q;
  rob_tag_t alu_tag_q;
  data_t    alu_value_q;

  // multiplier pipe, stage 0 loads from issue
  logic [MUL_LATENCY-1:0] mul_valid_pipe;
  rob_tag_t               mul_tag_pipe  [MUL_LATENCY];
  data_t                  mul_value_pipe[MUL_LATENCY];

  ////////////////////
  // alu path
  ////////////////////

  // add/sub wrap mod 2^16
  always_comb
  begin
    case (issue.op)
      OP_ADD:  alu_result = issue.a + issue.b;
      OP_SUB:  alu_result = issue.a - issue.b;
      OP_XOR:  alu_result = issue.a ^ issue.b;
      // multiplies go down the other path
      default: alu_result = '0;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      alu_valid_q <= 1'b0;
    end
    else
    begin
      alu_valid_q <= issue_valid && (issue.op != OP_MUL);
    end
  end

  always_ff @(posedge clock)
  begin
    alu_tag_q   <= issue.tag;
    alu_value_q <= alu_result;
  end

  assign alu_complete.valid = alu_valid_q;
  assign alu_complete.tag   = alu_tag_q;
  assign alu_complete.value = alu_value_q;

  ////////////////////
  // multiply path
  ////////////////////

  // 16-bit context keeps only the low half of the product
  assign mul_product = issue.a * issue.b;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      mul_valid_pipe <= '0;
    end
    else
    begin
      mul_valid_pipe[0] <= issue_valid && (issue.op == OP_MUL);
      for (int s = 1; s < MUL_LATENCY; s++)
      begin
        mul_valid_pipe[s] <= mul_valid_pipe[s-1];
      end
    end
  end

  // tag and product shift along with valid
  // several multiplies may be in flight
  always_ff @(posedge clock)
  begin
    mul_tag_pipe[0]   <= issue.tag;
    mul_value_pipe[0] <= mul_product;
    for (int s = 1; s < MUL_LATENCY; s++)
    begin
      mul_tag_pipe[s]   <= mul_tag_pipe[s-1];
      mul_value_pipe[s] <= mul_value_pipe[s-1];
    end
  end

  // last stage drives the bus
  assign mul_complete.valid = mul_valid_pipe[MUL_LATENCY-1];
  assign mul_complete.tag   = mul_tag_pipe[MUL_LATENCY-1];
  assign mul_complete.value = mul_value_pipe[MUL_LATENCY-1];

endmodule

// File: hdl/reorder_buffer.sv
// reorder buffer: circular entry array with head, tail and count
// completion writes, operand lookups, two-wide in-order retire
`timescale 1ns/100ps

module reorder_buffer (
  input  logic                clock,
  input  logic                reset,
  // allocation at the tail
  input  logic                alloc,
  input  core_pkg::reg_idx_t  alloc_dest,
  output core_pkg::rob_tag_t  alloc_tag,
  output logic                full,
  // operand lookups from decode
  input  core_pkg::rob_tag_t  lookup_tag_a,
  input  core_pkg::rob_tag_t  lookup_tag_b,
  output logic                lookup_done_a,
  output logic                lookup_done_b,
  output core_pkg::data_t     lookup_value_a,
  output core_pkg::data_t     lookup_value_b,
  // results from execute
  input  core_pkg::complete_t alu_complete,
  input  core_pkg::complete_t mul_complete,
  // retire slots, slot 0 is older
  output core_pkg::retire_t   retire0,
  output core_pkg::retire_t   retire1
);

  import core_pkg::*;

  // entry storage
  rob_state_t entry_state[ROB_DEPTH];
  reg_idx_t   entry_dest [ROB_DEPTH];
  data_t      entry_value[ROB_DEPTH];

  // pointers wrap on their own, depth is a power of two
  rob_tag_t   head;
  rob_tag_t   tail;
  rob_tag_t   head_next;
  rob_count_t count;
  logic [1:0] retire_n;

  ////////////////////
  // allocation
  ////////////////////

  // full by count, head == tail is ambiguous
  assign full      = (count == rob_count_t'(ROB_DEPTH));
  assign alloc_tag = tail;

  ////////////////////
  // lookups
  ////////////////////

  assign lookup_done_a  = (entry_state[lookup_tag_a] == ROBE_DONE);
  assign lookup_done_b  = (entry_state[lookup_tag_b] == ROBE_DONE);
  assign lookup_value_a = entry_value[lookup_tag_a];
  assign lookup_value_b = entry_value[lookup_tag_b];

  ////////////////////
  // retire select
  ////////////////////

  assign head_next = head + 1'b1;

  // slot 0 from the head, slot 1 only behind a valid slot 0
  assign retire0.valid = (entry_state[head] == ROBE_DONE);
  assign retire0.tag   = head;
  assign retire0.dest  = entry_dest[head];
  assign retire0.value = entry_value[head];

  assign retire1.valid = retire0.valid && (entry_state[head_next] == ROBE_DONE);
  assign retire1.tag   = head_next;
  assign retire1.dest  = entry_dest[head_next];
  assign retire1.value = entry_value[head_next];

  // entries leaving this cycle
  assign retire_n = {1'b0, retire0.valid} + {1'b0, retire1.valid};

  ////////////////////
  // pointers and count
  ////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end
    else
    begin
      head  <= head + rob_tag_t'(retire_n);
      tail  <= tail + rob_tag_t'(alloc);
      count <= count + rob_count_t'(alloc) - rob_count_t'(retire_n);
    end
  end

  ////////////////////
  // entry state
  ////////////////////

  // retire, alloc and completions never hit the same entry
  // alloc only while not full, completions only hit busy entries
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int e = 0; e < ROB_DEPTH; e++)
      begin
        entry_state[e] <= ROBE_EMPTY;
      end
    end
    else
    begin
      // free retiring entries
      if (retire0.valid)
      begin
        entry_state[head] <= ROBE_EMPTY;
      end
      if (retire1.valid)
      begin
        entry_state[head_next] <= ROBE_EMPTY;
      end
      // new entry waits for its result
      if (alloc)
      begin
        entry_state[tail] <= ROBE_BUSY;
      end
      // both paths may finish in one cycle, different tags
      if (alu_complete.valid)
      begin
        entry_state[alu_complete.tag] <= ROBE_DONE;
      end
      if (mul_complete.valid)
      begin
        entry_state[mul_complete.tag] <= ROBE_DONE;
      end
    end
  end

  // dest and value, qualified by state
  always_ff @(posedge clock)
  begin
    if (alloc)
    begin
      entry_dest[tail] <= alloc_dest;
    end
    if (alu_complete.valid)
    begin
      entry_value[alu_complete.tag] <= alu_complete.value;
    end
    if (mul_complete.valid)
    begin
      entry_value[mul_complete.tag] <= mul_complete.value;
    end
  end

endmodule

// File: hdl/commit_regfile.sv
// architectural register file, two combinational read ports
// and two ordered write ports fed by the retire slots
`timescale 1ns/100ps

module commit_regfile (
  input  logic               clock,
  input  logic               reset,
  // reads for decode
  input  core_pkg::reg_idx_t read_a,
  input  core_pkg::reg_idx_t read_b,
  output core_pkg::data_t    value_a,
  output core_pkg::data_t    value_b,
  // retire writes, slot 1 is younger
  input  core_pkg::retire_t  retire0,
  input  core_pkg::retire_t  retire1
);

  import core_pkg::*;

  data_t regs[NUM_REGS];

  ////////////////////
  // reads
  ////////////////////

  assign value_a = regs[read_a];
  assign value_b = regs[read_b];

  ////////////////////
  // writes
  ////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      // register i starts out holding i
      for (int r = 0; r < NUM_REGS; r++)
      begin
        regs[r] <= data_t'(r);
      end
    end
    else
    begin
      if (retire0.valid)
      begin
        regs[retire0.dest] <= retire0.value;
      end
      // later write, wins on a shared dest
      if (retire1.valid)
      begin
        regs[retire1.dest] <= retire1.value;
      end
    end
  end

endmodule

// File: hdl/ooo_core_top.sv
// core top level: decode, execute, reorder buffer and register file
// exposes the dispatch handshake and both retire slots
`timescale 1ns/100ps

module ooo_core_top #(
  parameter int MUL_LATENCY = 3
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              dispatch_valid,
  input  core_pkg::instr_t  dispatch_instr,
  output logic              dispatch_ready,
  output core_pkg::retire_t retire0,
  output core_pkg::retire_t retire1
);

  import core_pkg::*;

  // decode <-> rob
  logic      rob_full;
  logic      alloc;
  rob_tag_t  alloc_tag;
  rob_tag_t  lookup_tag_a;
  rob_tag_t  lookup_tag_b;
  logic      lookup_done_a;
  logic      lookup_done_b;
  data_t     lookup_value_a;
  data_t     lookup_value_b;
  // decode <-> regfile
  data_t     rf_value_a;
  data_t     rf_value_b;
  // decode -> execute
  logic      issue_valid;
  issue_t    issue;
  // execute -> rob
  complete_t alu_complete;
  complete_t mul_complete;

  decode_stage decode_stage_i (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_instr (dispatch_instr),
    .dispatch_ready (dispatch_ready),
    .rob_full       (rob_full),
    .alloc          (alloc),
    .alloc_tag      (alloc_tag),
    .lookup_tag_a   (lookup_tag_a),
    .lookup_tag_b   (lookup_tag_b),
    .lookup_done_a  (lookup_done_a),
    .lookup_done_b  (lookup_done_b),
    .lookup_value_a (lookup_value_a),
    .lookup_value_b (lookup_value_b),
    .rf_value_a     (rf_value_a),
    .rf_value_b     (rf_value_b),
    .retire0        (retire0),
    .retire1        (retire1),
    .issue_valid    (issue_valid),
    .issue          (issue)
  );

  execute_unit #(
    .MUL_LATENCY (MUL_LATENCY)
  ) execute_unit_i (
    .clock        (clock),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .alu_complete (alu_complete),
    .mul_complete (mul_complete)
  );

  reorder_buffer reorder_buffer_i (
    .clock          (clock),
    .reset          (reset),
    .alloc          (alloc),
    .alloc_dest     (dispatch_instr.dest),
    .alloc_tag      (alloc_tag),
    .full           (rob_full),
    .lookup_tag_a   (lookup_tag_a),
    .lookup_tag_b   (lookup_tag_b),
    .lookup_done_a  (lookup_done_a),
    .lookup_done_b  (lookup_done_b),
    .lookup_value_a (lookup_value_a),
    .lookup_value_b (lookup_value_b),
    .alu_complete   (alu_complete),
    .mul_complete   (mul_complete),
    .retire0        (retire0),
    .retire1        (retire1)
  );

  // read ports follow the dispatch sources directly
  commit_regfile commit_regfile_i (
    .clock   (clock),
    .reset   (reset),
    .read_a  (dispatch_instr.src1),
    .read_b  (dispatch_instr.src2),
    .value_a (rf_value_a),
    .value_b (rf_value_b),
    .retire0 (retire0),
    .retire1 (retire1)
  );

endmodule

// File: dv/clock_gen.sv
// testbench clock and synchronous reset source
`timescale 1ns/100ps

module clock_gen #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 5
) (
  output logic clock,
  output logic reset
);

  // free-running, 4 ns period
  initial
  begin
    clock = 1'b0;
    forever
    begin
      #(HALF_PERIOD) clock = ~clock;
    end
  end

  // reset over the first rising edges, dropped on a falling edge
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

// File: dv/core_tb.sv
// testbench for the reorder-buffer core: stimulus phases,
// program-order reference model and retire checking
`timescale 1ns/100ps

module core_tb;

  import core_pkg::*;

  localparam int MUL_LATENCY      = 20;
  localparam int NUM_RANDOM       = 200;
  localparam int NUM_MUL_BURST    = 20;
  localparam int DISPATCH_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT    = 500;
  localparam int RESET_TIMEOUT    = 50;

  // one expected retirement
  typedef struct packed {
    rob_tag_t tag;
    reg_idx_t dest;
    data_t    value;
  } expect_t;

  logic     clock;
  logic     reset;
  logic     dispatch_valid;
  instr_t   dispatch_instr;
  logic     dispatch_ready;
  retire_t  retire0;
  retire_t  retire1;

  integer   seed;
  data_t    model_regs[NUM_REGS];
  // tags are handed out in order around the circular buffer
  rob_tag_t next_tag;
  expect_t  expected_q[$];
  int       in_flight;
  int       mismatch_count;
  int       check_count;
  int       timeout_count;
  logic     prev_reset;
  // coverage flags for the end checks
  logic     saw_full_stall;
  logic     saw_ready_again;
  logic     saw_dual;
  logic     saw_dual_same_dest;

  clock_gen clock_gen_i (
    .clock (clock),
    .reset (reset)
  );

  ooo_core_top #(
    .MUL_LATENCY (MUL_LATENCY)
  ) ooo_core_top_i (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_instr (dispatch_instr),
    .dispatch_ready (dispatch_ready),
    .retire0        (retire0),
    .retire1        (retire1)
  );

  ////////////////////
  // reference model
  ////////////////////

  // op rules, 16-bit wrap, low half of the product
  function automatic data_t model_result(input op_t op, input data_t a, input data_t b);
    logic [31:0] product;
    product = {16'd0, a} * {16'd0, b};
    case (op)
      OP_ADD:  return data_t'(a + b);
      OP_SUB:  return data_t'(a - b);
      OP_XOR:  return a ^ b;
      default: return product[15:0];
    endcase
  endfunction

  function automatic instr_t make_instr(input op_t op, input int dest, input int src1,
                                        input int src2);
    instr_t instr;
    instr.op   = op;
    instr.dest = reg_idx_t'(dest);
    instr.src1 = reg_idx_t'(src1);
    instr.src2 = reg_idx_t'(src2);
    return instr;
  endfunction

  ////////////////////
  // checks
  ////////////////////

  // slot 1 only behind slot 0
  assert property (@(posedge clock) disable iff (reset) retire1.valid |-> retire0.valid)
  else
  begin
    check_count++;
    $display("error at %0t: retire slot 1 valid while slot 0 is not", $time);
  end

  // a full buffer must hold off dispatch
  assert property (@(posedge clock) disable iff (reset)
                   (in_flight == ROB_DEPTH) |-> !dispatch_ready)
  else
  begin
    check_count++;
    $display("error at %0t: dispatch ready with a full reorder buffer", $time);
  end

  // compare one retire slot with the oldest expected result
  task automatic check_retire(input retire_t slot, input int slot_num);
    expect_t exp;
    if (expected_q.size() == 0)
    begin
      check_count++;
      $display("error at %0t: retire slot %0d valid with nothing outstanding",
               $time, slot_num);
    end
    else
    begin
      exp = expected_q.pop_front();
      assert (slot.tag == exp.tag && slot.dest == exp.dest && slot.value == exp.value)
      else
      begin
        mismatch_count++;
        $display("Mismatch at %0t: slot %0d retired tag %0d r%0d=%h, expected tag %0d r%0d=%h",
                 $time, slot_num, slot.tag, slot.dest, slot.value,
                 exp.tag, exp.dest, exp.value);
      end
    end
  endtask

  // retire checks first, then the model takes an accepted instruction
  always @(posedge clock)
  begin
    int      retired;
    expect_t exp;
    if (prev_reset)
    begin
      assert (!retire0.valid && !retire1.valid && dispatch_ready)
      else
      begin
        check_count++;
        $display("error at %0t: retire valid or ready low during or right after reset",
                 $time);
      end
    end
    prev_reset = reset;
    if (!reset)
    begin
      retired = 0;
      if (retire0.valid)
      begin
        check_retire(retire0, 0);
        retired++;
      end
      if (retire1.valid)
      begin
        check_retire(retire1, 1);
        retired++;
      end
      if (retire0.valid && retire1.valid)
      begin
        saw_dual = 1'b1;
        if (retire0.dest == retire1.dest)
        begin
          saw_dual_same_dest = 1'b1;
        end
      end
      assert (in_flight <= ROB_DEPTH)
      else
      begin
        check_count++;
        $display("error at %0t: %0d entries in flight, more than the buffer holds",
                 $time, in_flight);
      end
      if (in_flight == ROB_DEPTH && !dispatch_ready)
      begin
        saw_full_stall = 1'b1;
      end
      if (saw_full_stall && dispatch_ready && in_flight < ROB_DEPTH)
      begin
        saw_ready_again = 1'b1;
      end
      if (dispatch_valid && dispatch_ready)
      begin
        exp.tag   = next_tag;
        exp.dest  = dispatch_instr.dest;
        exp.value = model_result(dispatch_instr.op, model_regs[dispatch_instr.src1],
                                 model_regs[dispatch_instr.src2]);
        model_regs[dispatch_instr.dest] = exp.value;
        expected_q.push_back(exp);
        next_tag = next_tag + 1'b1;
      end
      in_flight = in_flight + ((dispatch_valid && dispatch_ready) ? 1 : 0) - retired;
    end
  end

  ////////////////////
  // run control
  ////////////////////

  task automatic finish_run();
    int total;
    total = mismatch_count + check_count + timeout_count;
    $display("errors: %0d mismatch, %0d check, %0d timeout",
             mismatch_count, check_count, timeout_count);
    if (total == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  // drive on the falling edge, hold until accepted
  task automatic send_instr(input instr_t instr);
    int waited;
    // nothing more goes out once a wait has expired
    if (timeout_count != 0)
    begin
      return;
    end
    @(negedge clock);
    dispatch_valid = 1'b1;
    dispatch_instr = instr;
    waited = 0;
    @(posedge clock);
    while (!dispatch_ready && waited < DISPATCH_TIMEOUT)
    begin
      waited++;
      @(posedge clock);
    end
    if (!dispatch_ready)
    begin
      timeout_count++;
      $display("timeout at %0t: instruction not accepted after %0d cycles", $time, waited);
    end
  endtask

  task automatic go_idle();
    @(negedge clock);
    dispatch_valid = 1'b0;
  endtask

  // everything accepted so far has retired
  task automatic wait_drain();
    int waited;
    if (timeout_count != 0)
    begin
      return;
    end
    waited = 0;
    @(negedge clock);
    while (expected_q.size() != 0 && waited < DRAIN_TIMEOUT)
    begin
      waited++;
      @(negedge clock);
    end
    if (expected_q.size() != 0)
    begin
      timeout_count++;
      $display("timeout at %0t: %0d instructions never retired", $time, expected_q.size());
    end
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (reset && waited < RESET_TIMEOUT)
    begin
      waited++;
      @(negedge clock);
    end
    if (reset)
    begin
      timeout_count++;
      $display("timeout at %0t: reset never released", $time);
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial
  begin
    logic [31:0] rnd;
    seed               = 32'h8318_af28;
    dispatch_valid     = 1'b0;
    dispatch_instr     = '0;
    next_tag           = '0;
    in_flight          = 0;
    mismatch_count     = 0;
    check_count        = 0;
    timeout_count      = 0;
    prev_reset         = 1'b0;
    saw_full_stall     = 1'b0;
    saw_ready_again    = 1'b0;
    saw_dual           = 1'b0;
    saw_dual_same_dest = 1'b0;
    for (int r = 0; r < NUM_REGS; r++)
    begin
      model_regs[r] = data_t'(r);
    end
    wait_reset_release();

    // dependency chain, each reads the one before
    send_instr(make_instr(OP_ADD, 1, 1, 2));
    send_instr(make_instr(OP_MUL, 2, 1, 1));
    send_instr(make_instr(OP_SUB, 3, 2, 1));
    send_instr(make_instr(OP_XOR, 4, 3, 2));
    send_instr(make_instr(OP_ADD, 5, 4, 3));
    send_instr(make_instr(OP_MUL, 6, 5, 4));
    send_instr(make_instr(OP_SUB, 7, 6, 5));
    send_instr(make_instr(OP_ADD, 0, 7, 6));
    go_idle();
    wait_drain();

    // independent multiplies, sources never written here, fills the buffer
    for (int i = 0; i < NUM_MUL_BURST; i++)
    begin
      send_instr(make_instr(OP_MUL, 4 + (i % 4), i % 4, (i + 1) % 4));
    end
    go_idle();
    wait_drain();

    // slow multiply ahead of a fast add
    send_instr(make_instr(OP_MUL, 7, 2, 3));
    send_instr(make_instr(OP_ADD, 1, 2, 3));
    // pair on r1 retiring together behind the multiply
    send_instr(make_instr(OP_ADD, 1, 1, 4));
    send_instr(make_instr(OP_XOR, 1, 4, 5));
    // r1 reader, once from the buffer and once from the register file
    send_instr(make_instr(OP_SUB, 6, 1, 2));
    go_idle();
    wait_drain();
    send_instr(make_instr(OP_SUB, 0, 1, 6));
    go_idle();
    wait_drain();

    // random mix
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      rnd = $random(seed);
      send_instr(make_instr(op_t'(rnd[1:0]), rnd[4:2], rnd[7:5], rnd[10:8]));
    end
    go_idle();
    wait_drain();

    // end of run coverage, only meaningful when every phase completed
    if (timeout_count == 0)
    begin
      assert (saw_full_stall && saw_ready_again)
      else
      begin
        check_count++;
        $display("error: buffer never filled with dispatch held off, or never recovered");
      end
      assert (saw_dual)
      else
      begin
        check_count++;
        $display("error: no cycle retired two entries");
      end
      assert (saw_dual_same_dest)
      else
      begin
        check_count++;
        $display("error: no cycle retired two entries to the same register");
      end
    end
    finish_run();
  end

endmodule

// File: filelist.f
hdl/core_pkg.sv
hdl/decode_stage.sv
hdl/execute_unit.sv
hdl/reorder_buffer.sv
hdl/commit_regfile.sv
hdl/ooo_core_top.sv
dv/clock_gen.sv
dv/core_tb.sv
